// File: hw/axi_resp_pkg.sv
`default_nettype none

package axi_resp_pkg;

    // Transaction ID width shared by both channels
    localparam int ID_WIDTH = 8;

    // Read data width of one R beat
    localparam int DATA_WIDTH = 32;

    // Entries per response FIFO
    // Kept a power of two so the pointers wrap without compare logic
    localparam int FIFO_DEPTH = 16;

    // FIFO pointer width
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);

    // AXI response code as driven on BRESP and RRESP
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_t;

    // One direct error raised by the request path
    // Carries only the ID and the code since the beat is built later
    typedef struct packed {
        logic [ID_WIDTH-1:0] id;
        resp_t               resp;
    } err_t;

    // One write response on the B channel
    typedef struct packed {
        logic [ID_WIDTH-1:0] id;
        resp_t               resp;
    } b_beat_t;

    // One read beat on the R channel
    // Field order matches RID, RDATA, RRESP, RLAST from top down
    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [DATA_WIDTH-1:0] data;
        resp_t                 resp;
        logic                  last;
    } r_beat_t;

endpackage : axi_resp_pkg

`default_nettype wire

// File: hw/resp_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module resp_fifo
    import axi_resp_pkg::*;
#(
    parameter type item_t = b_beat_t
) (
    input  wire logic  clk,
    input  wire logic  arst,
    // Write side from the completion logic
    input  wire logic  push,
    input  wire item_t push_data,
    output logic       full,
    // Show-ahead read side towards the select stage
    input  wire logic  pop,
    output item_t      rd_data,
    output logic       empty
);

    // Storage array
    item_t mem [FIFO_DEPTH];

    // Pointers and fill level
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;

    // Qualified enables
    logic wr_en;
    logic rd_en;

    assign full  = (count == (FIFO_AW+1)'(FIFO_DEPTH));
    assign empty = (count == '0);

    // Guard against overflow and underflow even if a caller misbehaves
    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    // Head is visible whenever the FIFO is not empty
    assign rd_data = mem[rd_ptr];

    // Item written on the push edge
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge arst) begin
        if (!arst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Count moves only when exactly one side is active
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Producer outside this block must check full before pushing
    a_no_push_full: assert property (@(posedge clk) disable iff (!arst)
        push |-> !full);

    // Select stage pops only a head it has actually offered
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst)
        pop |-> !empty);

endmodule : resp_fifo

`default_nettype wire

// File: hw/write_resp_select.sv
`timescale 1ns/1ps
`default_nettype none

module write_resp_select
    import axi_resp_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    arst,
    // Direct error strobe from the AW request path
    input  wire logic    err_valid,
    input  wire err_t    err,
    // Head of the B FIFO
    input  wire b_beat_t fifo_data,
    input  wire logic    fifo_empty,
    output logic         fifo_pop,
    // Offer towards the output slice
    output b_beat_t      out_beat,
    output logic         out_valid,
    input  wire logic    out_ready
);

    // Pending error slot
    logic slot_valid;
    err_t slot_err;

    // Beat accepted by the slice this cycle
    logic xfer;

    assign out_valid = slot_valid || !fifo_empty;
    assign xfer      = out_valid && out_ready;

    // FIFO head leaves only when it was the beat on offer
    assign fifo_pop = xfer && !slot_valid;

    // Pending error wins over the FIFO head
    // A newly captured error may replace a FIFO head still waiting on the slice
    always_comb begin
        if (slot_valid) begin
            out_beat.id   = slot_err.id;
            out_beat.resp = slot_err.resp;
        end else begin
            out_beat = fifo_data;
        end
    end

    // Error payload captured on the strobe edge
    always_ff @(posedge clk) begin
        if (err_valid) begin
            slot_err <= err;
        end
    end

    always_ff @(posedge clk or negedge arst) begin
        if (!arst) begin
            slot_valid <= 1'b0;
        end else if (err_valid) begin
            slot_valid <= 1'b1;
        end else if (xfer && slot_valid) begin
            // Slot frees once the slice takes the error
            slot_valid <= 1'b0;
        end
    end

    // AW path has no back-pressure so it must wait for the slot to drain
    a_slot_free: assert property (@(posedge clk) disable iff (!arst)
        err_valid |-> !slot_valid);

endmodule : write_resp_select

`default_nettype wire

// File: hw/read_resp_select.sv
`timescale 1ns/1ps
`default_nettype none

module read_resp_select
    import axi_resp_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    arst,
    // Direct error strobe from the AR request path
    input  wire logic    err_valid,
    input  wire err_t    err,
    // Head of the R FIFO
    input  wire r_beat_t fifo_data,
    input  wire logic    fifo_empty,
    output logic         fifo_pop,
    // Offer towards the output slice
    output r_beat_t      out_beat,
    output logic         out_valid,
    input  wire logic    out_ready
);

    // Pending error slot
    logic slot_valid;
    err_t slot_err;

    // Beat accepted by the slice this cycle
    logic xfer;

    assign out_valid = slot_valid || !fifo_empty;
    assign xfer      = out_valid && out_ready;

    // Pop only when the FIFO head itself transfers
    assign fifo_pop = xfer && !slot_valid;

    // Error expands into a single-beat burst
    // Data is zero and last is set so the master closes the read
    always_comb begin
        if (slot_valid) begin
            out_beat = '{
                id:   slot_err.id,
                data: '0,
                resp: slot_err.resp,
                last: 1'b1
            };
        end else begin
            out_beat = fifo_data;
        end
    end

    // Only ID and code are stored since the rest is constant
    always_ff @(posedge clk) begin
        if (err_valid) begin
            slot_err <= err;
        end
    end

    always_ff @(posedge clk or negedge arst) begin
        if (!arst) begin
            slot_valid <= 1'b0;
        end else if (err_valid) begin
            slot_valid <= 1'b1;
        end else if (xfer && slot_valid) begin
            // Error beat handed to the slice
            slot_valid <= 1'b0;
        end
    end

    // AR path raises at most one outstanding error
    a_slot_free: assert property (@(posedge clk) disable iff (!arst)
        err_valid |-> !slot_valid);

endmodule : read_resp_select

`default_nettype wire

// File: hw/resp_out_slice.sv
`timescale 1ns/1ps
`default_nettype none

module resp_out_slice #(
    parameter type item_t = logic
) (
    input  wire logic  clk,
    input  wire logic  arst,
    // Upstream side from the select stage
    input  wire item_t in_beat,
    input  wire logic  in_valid,
    output logic       in_ready,
    // Master-facing channel
    output item_t      m_beat,
    output logic       m_valid,
    input  wire logic  m_ready
);

    // Two skid entries used as a tiny ring
    item_t      entry [2];
    logic       wr_sel;
    logic       rd_sel;
    logic [1:0] count;

    logic in_xfer;
    logic m_xfer;

    // Ready depends only on local fill so master ready never reaches upstream
    assign in_ready = (count != 2'd2);
    assign m_valid  = (count != 2'd0);
    assign m_beat   = entry[rd_sel];

    assign in_xfer = in_valid && in_ready;
    assign m_xfer  = m_valid && m_ready;

    always_ff @(posedge clk) begin
        if (in_xfer) begin
            entry[wr_sel] <= in_beat;
        end
    end

    always_ff @(posedge clk or negedge arst) begin
        if (!arst) begin
            wr_sel <= 1'b0;
            rd_sel <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (in_xfer) begin
                wr_sel <= !wr_sel;
            end
            if (m_xfer) begin
                rd_sel <= !rd_sel;
            end
            // Simultaneous in and out keeps the level at full rate
            case ({in_xfer, m_xfer})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    // A stalled beat on the master side does not change
    a_hold: assert property (@(posedge clk) disable iff (!arst)
        m_valid && !m_ready |=> m_valid && $stable(m_beat));

endmodule : resp_out_slice

`default_nettype wire

// File: hw/axi_resp_path.sv
`timescale 1ns/1ps
`default_nettype none

module axi_resp_path
    import axi_resp_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    arst,
    // Write-response queue
    input  wire logic    b_push,
    input  wire b_beat_t b_push_data,
    output logic         b_full,
    // Read-beat queue
    input  wire logic    r_push,
    input  wire r_beat_t r_push_data,
    output logic         r_full,
    // Direct errors from the request path
    input  wire logic    aw_err_valid,
    input  wire err_t    aw_err,
    input  wire logic    ar_err_valid,
    input  wire err_t    ar_err,
    // B channel
    output b_beat_t      b_beat,
    output logic         bvalid,
    input  wire logic    bready,
    // R channel
    output r_beat_t      r_beat,
    output logic         rvalid,
    input  wire logic    rready
);

    // B pipeline hand-off
    b_beat_t b_fifo_data;
    logic    b_fifo_empty;
    logic    b_fifo_pop;
    b_beat_t b_sel_beat;
    logic    b_sel_valid;
    logic    b_sel_ready;

    // R pipeline hand-off
    r_beat_t r_fifo_data;
    logic    r_fifo_empty;
    logic    r_fifo_pop;
    r_beat_t r_sel_beat;
    logic    r_sel_valid;
    logic    r_sel_ready;

    // Write response path
    resp_fifo #(.item_t(b_beat_t)) u_b_fifo (
        .clk       (clk),
        .arst      (arst),
        .push      (b_push),
        .push_data (b_push_data),
        .full      (b_full),
        .pop       (b_fifo_pop),
        .rd_data   (b_fifo_data),
        .empty     (b_fifo_empty)
    );

    write_resp_select u_b_select (
        .clk        (clk),
        .arst       (arst),
        .err_valid  (aw_err_valid),
        .err        (aw_err),
        .fifo_data  (b_fifo_data),
        .fifo_empty (b_fifo_empty),
        .fifo_pop   (b_fifo_pop),
        .out_beat   (b_sel_beat),
        .out_valid  (b_sel_valid),
        .out_ready  (b_sel_ready)
    );

    resp_out_slice #(.item_t(b_beat_t)) u_b_slice (
        .clk      (clk),
        .arst     (arst),
        .in_beat  (b_sel_beat),
        .in_valid (b_sel_valid),
        .in_ready (b_sel_ready),
        .m_beat   (b_beat),
        .m_valid  (bvalid),
        .m_ready  (bready)
    );

    // Read data path
    resp_fifo #(.item_t(r_beat_t)) u_r_fifo (
        .clk       (clk),
        .arst      (arst),
        .push      (r_push),
        .push_data (r_push_data),
        .full      (r_full),
        .pop       (r_fifo_pop),
        .rd_data   (r_fifo_data),
        .empty     (r_fifo_empty)
    );

    read_resp_select u_r_select (
        .clk        (clk),
        .arst       (arst),
        .err_valid  (ar_err_valid),
        .err        (ar_err),
        .fifo_data  (r_fifo_data),
        .fifo_empty (r_fifo_empty),
        .fifo_pop   (r_fifo_pop),
        .out_beat   (r_sel_beat),
        .out_valid  (r_sel_valid),
        .out_ready  (r_sel_ready)
    );

    resp_out_slice #(.item_t(r_beat_t)) u_r_slice (
        .clk      (clk),
        .arst     (arst),
        .in_beat  (r_sel_beat),
        .in_valid (r_sel_valid),
        .in_ready (r_sel_ready),
        .m_beat   (r_beat),
        .m_valid  (rvalid),
        .m_ready  (rready)
    );

endmodule : axi_resp_path

`default_nettype wire

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic arst
);

    // Free-running clock, first rising edge half a period in
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // Reset low for the given cycles, released on a falling edge
    initial begin
        arst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst = 1'b1;
    end

endmodule : tb_clock_gen

`default_nettype wire

// File: tests/axi_resp_path_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axi_resp_path_tb
    import axi_resp_pkg::*;
();

    localparam int CLK_NS       = 8;
    localparam int RESET_CYCLES = 8;
    localparam int N_ORDER      = 40;
    localparam int N_RAND       = 300;
    localparam int FILL_PUSHES  = 18;
    localparam int DRAIN_LIMIT  = 64;
    // Every stimulus phase plus five bounded drains
    localparam int TEST_CYCLES  = RESET_CYCLES + N_ORDER + N_RAND + FILL_PUSHES
                                  + 5 * DRAIN_LIMIT + 16;
    // Double the test length as margin
    localparam int WATCHDOG_NS  = 2 * TEST_CYCLES * CLK_NS;

    logic    clk;
    logic    arst;
    logic    b_push;
    b_beat_t b_push_data;
    logic    b_full;
    logic    r_push;
    r_beat_t r_push_data;
    logic    r_full;
    logic    aw_err_valid;
    err_t    aw_err;
    logic    ar_err_valid;
    err_t    ar_err;
    b_beat_t b_beat;
    logic    bvalid;
    logic    bready;
    r_beat_t r_beat;
    logic    rvalid;
    logic    rready;

    integer seed;
    int     value_errors;
    int     flow_errors;

    // Expected beats per channel in delivery order
    b_beat_t b_q[$];
    r_beat_t r_q[$];
    // Queue heads mirrored into plain variables for the assertions
    b_beat_t b_exp_head;
    r_beat_t r_exp_head;
    logic    b_exp_any;
    logic    r_exp_any;
    // Master-side beats from the previous edge
    b_beat_t b_prev;
    r_beat_t r_prev;
    // Phase flags that enable the latency and full checks
    logic    lat_mode;
    logic    fill_check;

    tb_clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
        .clk  (clk),
        .arst (arst)
    );

    axi_resp_path UUT (
        .clk          (clk),
        .arst         (arst),
        .b_push       (b_push),
        .b_push_data  (b_push_data),
        .b_full       (b_full),
        .r_push       (r_push),
        .r_push_data  (r_push_data),
        .r_full       (r_full),
        .aw_err_valid (aw_err_valid),
        .aw_err       (aw_err),
        .ar_err_valid (ar_err_valid),
        .ar_err       (ar_err),
        .b_beat       (b_beat),
        .bvalid       (bvalid),
        .bready       (bready),
        .r_beat       (r_beat),
        .rvalid       (rvalid),
        .rready       (rready)
    );

    function automatic bit random_bit();
        return bit'($random(seed) & 1);
    endfunction

    function automatic b_beat_t random_b_beat();
        logic [31:0] bits;
        bits = $random(seed);
        return '{id: bits[ID_WIDTH-1:0], resp: resp_t'(bits[9:8])};
    endfunction

    function automatic r_beat_t random_r_beat();
        logic [31:0] bits;
        logic [31:0] payload;
        bits    = $random(seed);
        payload = $random(seed);
        return '{id: bits[ID_WIDTH-1:0], data: payload, resp: resp_t'(bits[9:8]),
                 last: bits[12]};
    endfunction

    function automatic err_t random_err();
        logic [31:0] bits;
        bits = $random(seed);
        return '{id: bits[ID_WIDTH-1:0], resp: resp_t'(bits[9:8])};
    endfunction

    // Direct errors as the master must see them
    function automatic b_beat_t err_as_b(input err_t e);
        return '{id: e.id, resp: e.resp};
    endfunction

    // A read error closes the burst with zero data
    function automatic r_beat_t err_as_r(input err_t e);
        return '{id: e.id, data: '0, resp: e.resp, last: 1'b1};
    endfunction

    function automatic void refresh_heads();
        b_exp_any  = (b_q.size() != 0);
        r_exp_any  = (r_q.size() != 0);
        b_exp_head = '0;
        r_exp_head = '0;
        if (b_exp_any) begin
            b_exp_head = b_q[0];
        end
        if (r_exp_any) begin
            r_exp_head = r_q[0];
        end
    endfunction

    // One falling-edge drive of optional pushes and the ready levels
    task automatic step(input bit try_b, input bit try_r, input bit rdy_b, input bit rdy_r);
        @(negedge clk);
        aw_err_valid = 1'b0;
        ar_err_valid = 1'b0;
        bready       = rdy_b;
        rready       = rdy_r;
        b_push       = try_b && !b_full;
        r_push       = try_r && !r_full;
        if (b_push) begin
            b_push_data = random_b_beat();
            b_q.push_back(b_push_data);
        end
        if (r_push) begin
            r_push_data = random_r_beat();
            r_q.push_back(r_push_data);
        end
        refresh_heads();
    endtask

    // Behind a full slice the error lands after its two beats
    task automatic strobe_errors(input bit behind_slice);
        int b_pos;
        int r_pos;
        @(negedge clk);
        b_pos        = behind_slice ? 2 : b_q.size();
        r_pos        = behind_slice ? 2 : r_q.size();
        b_push       = 1'b0;
        r_push       = 1'b0;
        aw_err_valid = 1'b1;
        aw_err       = random_err();
        ar_err_valid = 1'b1;
        ar_err       = random_err();
        b_q.insert(b_pos, err_as_b(aw_err));
        r_q.insert(r_pos, err_as_r(ar_err));
        refresh_heads();
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((b_q.size() != 0 || r_q.size() != 0) && cycles < DRAIN_LIMIT) begin
            step(1'b0, 1'b0, 1'b1, 1'b1);
            cycles++;
        end
        // Every expected beat must have reached the master
        all_delivered: assert (b_q.size() == 0 && r_q.size() == 0)
            else begin
                flow_errors++;
                $display("Beats not delivered after %0d cycles: %0d on B, %0d on R",
                         DRAIN_LIMIT, b_q.size(), r_q.size());
            end
    endtask

    // Model retires a beat on every master handshake
    always @(posedge clk) begin
        if (arst) begin
            if (bvalid && bready && b_q.size() != 0) begin
                void'(b_q.pop_front());
            end
            if (rvalid && rready && r_q.size() != 0) begin
                void'(r_q.pop_front());
            end
            refresh_heads();
        end
        b_prev <= b_beat;
        r_prev <= r_beat;
    end

    reset_state: assert property (@(posedge clk) $rose(arst) |->
        !bvalid && !rvalid && !b_full && !r_full)
        else begin
            value_errors++;
            $display("Fail reset bvalid %h rvalid %h b_full %h r_full %h (expected 0)",
                     $sampled(bvalid), $sampled(rvalid), $sampled(b_full), $sampled(r_full));
        end

    b_extra: assert property (@(posedge clk) disable iff (!arst)
        bvalid && bready |-> b_exp_any)
        else begin
            flow_errors++;
            $display("B channel delivered a beat that was never expected");
        end

    r_extra: assert property (@(posedge clk) disable iff (!arst)
        rvalid && rready |-> r_exp_any)
        else begin
            flow_errors++;
            $display("R channel delivered a beat that was never expected");
        end

    // Order and contents of every accepted beat
    b_match: assert property (@(posedge clk) disable iff (!arst)
        bvalid && bready && b_exp_any |-> b_beat == b_exp_head)
        else begin
            value_errors++;
            $display("Fail b_beat expected %h got %h", $sampled(b_exp_head), $sampled(b_beat));
        end

    r_match: assert property (@(posedge clk) disable iff (!arst)
        rvalid && rready && r_exp_any |-> r_beat == r_exp_head)
        else begin
            value_errors++;
            $display("Fail r_beat expected %h got %h", $sampled(r_exp_head), $sampled(r_beat));
        end

    // Stalled beats stay put until the handshake
    b_valid_hold: assert property (@(posedge clk) disable iff (!arst)
        bvalid && !bready |=> bvalid)
        else begin
            flow_errors++;
            $display("bvalid dropped before the master accepted the beat");
        end

    r_valid_hold: assert property (@(posedge clk) disable iff (!arst)
        rvalid && !rready |=> rvalid)
        else begin
            flow_errors++;
            $display("rvalid dropped before the master accepted the beat");
        end

    b_stable: assert property (@(posedge clk) disable iff (!arst)
        bvalid && !bready |=> b_beat == b_prev)
        else begin
            value_errors++;
            $display("Fail b_beat expected %h got %h", $sampled(b_prev), $sampled(b_beat));
        end

    r_stable: assert property (@(posedge clk) disable iff (!arst)
        rvalid && !rready |=> r_beat == r_prev)
        else begin
            value_errors++;
            $display("Fail r_beat expected %h got %h", $sampled(r_prev), $sampled(r_beat));
        end

    // 16 beats in the FIFO and 2 in the slice
    full_after_fill: assert property (@(posedge clk) disable iff (!arst)
        fill_check |-> b_full && r_full)
        else begin
            value_errors++;
            $display("Fail b_full expected 1 got %h, r_full expected 1 got %h",
                     $sampled(b_full), $sampled(r_full));
        end

    // Slot register then slice register on an idle path
    b_err_latency: assert property (@(posedge clk) disable iff (!arst)
        lat_mode && aw_err_valid |-> ##1 !bvalid ##1 bvalid)
        else begin
            flow_errors++;
            $display("Direct write error did not reach B two cycles after its strobe");
        end

    r_err_latency: assert property (@(posedge clk) disable iff (!arst)
        lat_mode && ar_err_valid |-> ##1 !rvalid ##1 rvalid)
        else begin
            flow_errors++;
            $display("Direct read error did not reach R two cycles after its strobe");
        end

    initial begin
        seed         = 68022;
        value_errors = 0;
        flow_errors  = 0;
        b_push       = 1'b0;
        b_push_data  = '0;
        r_push       = 1'b0;
        r_push_data  = '0;
        aw_err_valid = 1'b0;
        aw_err       = '0;
        ar_err_valid = 1'b0;
        ar_err       = '0;
        bready       = 1'b0;
        rready       = 1'b0;
        lat_mode     = 1'b0;
        fill_check   = 1'b0;
        refresh_heads();
        wait (arst === 1'b1);
        repeat (2) step(1'b0, 1'b0, 1'b0, 1'b0);

        // Full-rate ordering with ready high
        repeat (N_ORDER) step(1'b1, 1'b1, 1'b1, 1'b1);
        wait_drain();

        // Random pushes against random ready
        repeat (N_RAND) begin
            step(random_bit() || random_bit(), random_bit() || random_bit(),
                 random_bit(), random_bit());
        end
        wait_drain();

        // Fill FIFO and slice with the master stalled
        repeat (FILL_PUSHES) step(1'b1, 1'b1, 1'b0, 1'b0);
        step(1'b0, 1'b0, 1'b0, 1'b0);
        fill_check = 1'b1;
        step(1'b0, 1'b0, 1'b0, 1'b0);
        fill_check = 1'b0;

        // Error overtakes the FIFO items but not the slice
        strobe_errors(1'b1);
        repeat (3) step(1'b0, 1'b0, 1'b0, 1'b0);
        wait_drain();

        // Error format and latency on an idle path
        lat_mode = 1'b1;
        repeat (2) begin
            strobe_errors(1'b0);
            wait_drain();
        end
        lat_mode = 1'b0;

        repeat (4) step(1'b0, 1'b0, 1'b1, 1'b1);
        $display("Errors: value %0d, flow %0d", value_errors, flow_errors);
        if (value_errors == 0 && flow_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        flow_errors++;
        $display("Timeout: run still going after %0d ns", WATCHDOG_NS);
        $display("Errors: value %0d, flow %0d", value_errors, flow_errors);
        $display("** FAIL **");
        $finish;
    end

endmodule : axi_resp_path_tb

`default_nettype wire

// File: axi_resp_path.f
hw/axi_resp_pkg.sv
hw/resp_fifo.sv
hw/write_resp_select.sv
hw/read_resp_select.sv
hw/resp_out_slice.sv
hw/axi_resp_path.sv
tests/tb_clock_gen.sv
tests/axi_resp_path_tb.sv
